// File: Bender.yml
package:
  name: vector_engine

sources:
  - source/vector_pkg.sv
  - source/shape_rom.sv
  - source/display_list_sequencer.sv
  - source/line_rasterizer.sv
  - source/vector_engine.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_vector_engine.sv

// File: vector_engine.f
+incdir+testbench
source/vector_pkg.sv
source/shape_rom.sv
source/display_list_sequencer.sv
source/line_rasterizer.sv
source/vector_engine.sv
testbench/tb_vector_engine.sv

// File: testbench/tb_shapes.svh
// Reference shape lists and segment rule, included inside the vector engine testbench module
`ifndef TB_SHAPES_SVH
`define TB_SHAPES_SVH

localparam logic [7:0] op_move = 8'd0;
localparam logic [7:0] op_line = 8'd1;
localparam logic [7:0] op_end  = 8'd2;

// Each word is op, x, y
localparam logic [0:29][23:0] shape_list = {
    {op_move, 8'd0, 8'd254}, {op_line, 8'd0, 8'd0}, {op_line, 8'd254, 8'd0},     // Frame
    {op_line, 8'd254, 8'd254}, {op_line, 8'd0, 8'd254}, {op_end, 8'd0, 8'd0},
    {op_move, 8'd22, 8'd50}, {op_line, 8'd42, 8'd50}, {op_move, 8'd32, 8'd40},   // Cursor
    {op_line, 8'd32, 8'd60}, {op_end, 8'd0, 8'd0},
    {op_move, 8'd7, 8'd6}, {op_line, 8'd11, 8'd7}, {op_line, 8'd11, 8'd9},       // Patriot base
    {op_line, 8'd22, 8'd9}, {op_line, 8'd22, 8'd7}, {op_line, 8'd27, 8'd6},
    {op_move, 8'd3, 8'd14}, {op_line, 8'd22, 8'd31}, {op_line, 8'd25, 8'd27},
    {op_line, 8'd8, 8'd10}, {op_line, 8'd4, 8'd14}, {op_move, 8'd15, 8'd9},
    {op_line, 8'd14, 8'd16}, {op_move, 8'd18, 8'd9}, {op_line, 8'd16, 8'd18},
    {op_end, 8'd0, 8'd0},
    {op_move, 8'd0, 8'd0}, {op_line, 8'd0, 8'd0}, {op_end, 8'd0, 8'd0}           // Missile
};

localparam logic [0:3][7:0] list_start = {8'd0, 8'd6, 8'd11, 8'd27};

logic [31:0] exp_segs [$];  // x0, y0, x1, y1 after the offset

// Longer axis plus one, both endpoints drawn
function automatic int seg_pixels(input logic [31:0] seg);
    int dx;
    int dy;
    dx = int'(seg[15:8]) - int'(seg[31:24]);
    dy = int'(seg[7:0]) - int'(seg[23:16]);
    dx = (dx < 0) ? -dx : dx;
    dy = (dy < 0) ? -dy : dy;
    return ((dx > dy) ? dx : dy) + 1;
endfunction

// Queues one request's segments, returns its pixel total
function automatic int expect_segments(input int shape, input logic [7:0] ox,
                                       input logic [7:0] oy, output int entries);
    int idx;
    int pixels;
    logic [7:0] op;
    logic [7:0] vx;
    logic [7:0] vy;
    logic [7:0] px;
    logic [7:0] py;
    idx = list_start[shape];
    pixels = 0;
    entries = 0;
    op = op_move;
    px = ox;
    py = oy;
    while (op != op_end) begin
        {op, vx, vy} = shape_list[idx];
        vx = vx + ox;  // Wraps at 256
        vy = vy + oy;
        if (op == op_line) begin
            exp_segs.push_back({px, py, vx, vy});
            pixels += seg_pixels({px, py, vx, vy});
        end
        px = vx;
        py = vy;
        idx++;
        entries++;
    end
    return pixels;
endfunction

`endif

// File: testbench/tb_vector_engine.sv
// Self-checking testbench that draws the kept shapes through the vector engine at fixed and random offsets
`timescale 1ns/1ps

module tb_vector_engine;
    import vector_pkg::*;

    localparam int reset_cycles = 8;

    logic      clk;
    logic      rst;
    logic      start;
    shape_id_t shape;
    coord_t    offset_x;
    coord_t    offset_y;
    logic      busy;
    logic      done;
    logic      pixel_valid;
    coord_t    pixel_x;
    coord_t    pixel_y;

    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    int     cycle_limit;
    int     done_count;
    int     accepted;
    int     pixel_total;
    int     seg_count;     // Pixels so far in the current segment
    coord_t last_x;
    coord_t last_y;
    logic   expect_busy;

    `include "tb_shapes.svh"

    vector_engine dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .shape       (shape),
        .offset_x    (offset_x),
        .offset_y    (offset_y),
        .busy        (busy),
        .done        (done),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_quiet();
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("pixel_valid", 0, pixel_valid);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > test_errors) begin
            tests_failed++;
        end
        $display("%s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////
    // Checkers

    assert property (@(posedge clk) disable iff (rst) pixel_valid |-> busy) else begin
        $display("Pixel strobe at %0t while the engine is idle", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst) done |-> busy) else begin
        $display("Done strobe at %0t outside a request", $time);
        errors++;
    end

    task automatic check_pixel();
        logic [31:0] seg;
        int step_x;
        int step_y;
        pixel_total++;
        if (exp_segs.size() == 0) begin
            $display("Pixel at %0t arrived with no segment pending", $time);
            errors++;
            return;
        end
        seg = exp_segs[0];
        step_x = int'(pixel_x) - int'(last_x);
        step_y = int'(pixel_y) - int'(last_y);
        if (seg_count == 0) begin
            check_value("pixel_x", seg[31:24], pixel_x);  // Start point
            check_value("pixel_y", seg[23:16], pixel_y);
        end else begin
            assert (step_x >= -1 && step_x <= 1 && step_y >= -1 && step_y <= 1) else begin
                $display("Pixel at %0t is not a neighbour of the one before", $time);
                errors++;
            end
        end
        last_x = pixel_x;
        last_y = pixel_y;
        seg_count++;
        if (seg_count == seg_pixels(seg)) begin
            check_value("pixel_x", seg[15:8], pixel_x);  // End point
            check_value("pixel_y", seg[7:0], pixel_y);
            void'(exp_segs.pop_front());
            seg_count = 0;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            expect_busy = 1'b0;
            seg_count = 0;
        end else begin
            if (expect_busy) begin
                check_value("busy", 1, busy);
            end
            if (done) begin
                done_count++;
                expect_busy = 1'b0;
                check_value("segments left", 0, exp_segs.size() + seg_count);
            end
            if (start && !busy) begin
                accepted++;
                expect_busy = 1'b1;
            end
            if (pixel_valid) begin
                check_pixel();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, a request never finished", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////
    // Stimulus

    // Draws one request and sends an extra start poke_at cycles in when poke_at is above zero
    task automatic draw(input shape_id_t s, input coord_t ox, input coord_t oy,
                        input int poke_at);
        int entries;
        int pixels;
        int pixels_before;
        int done_before;
        int accepted_before;
        pixels = expect_segments(s, ox, oy, entries);
        cycle_limit += 2 * (entries + pixels + 4);
        pixels_before = pixel_total;
        done_before = done_count;
        accepted_before = accepted;
        @(posedge clk);
        start <= 1'b1;
        shape <= s;
        offset_x <= ox;
        offset_y <= oy;
        @(posedge clk);
        start <= 1'b0;
        if (poke_at > 0) begin
            repeat (poke_at) @(posedge clk);
            assert (busy) else begin
                $display("Engine went idle at %0t before the extra start", $time);
                errors++;
            end
            start <= 1'b1;
            shape <= shape_missile;
            offset_x <= 8'd77;
            @(posedge clk);
            start <= 1'b0;
        end
        do @(posedge clk); while (!done);
        @(negedge clk);
        check_value("pixel count", pixels, pixel_total - pixels_before);
        check_value("done pulses", 1, done_count - done_before);
        check_value("accepted starts", 1, accepted - accepted_before);
    endtask

    initial begin
        void'($urandom(96));
        rst = 1'b1;
        start = 1'b0;
        shape = shape_frame;
        offset_x = '0;
        offset_y = '0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        cycle_limit = reset_cycles + 16;
        done_count = 0;
        accepted = 0;
        pixel_total = 0;
        last_x = '0;
        last_y = '0;

        repeat (reset_cycles - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        finish_test("reset");

        draw(shape_frame, 8'd0, 8'd0, 0);
        finish_test("frame at origin");

        draw(shape_cursor, 8'd250, 8'd252, 0);
        draw(shape_patriot_base, 8'd248, 8'd251, 0);
        finish_test("offset wrap");

        draw(shape_missile, 8'd100, 8'd37, 0);
        finish_test("zero length segment");

        draw(shape_frame, 8'd3, 8'd5, 10);
        finish_test("start while busy");

        repeat (20) begin
            draw(shape_id_t'($urandom_range(3, 0)), coord_t'($urandom), coord_t'($urandom), 0);
            repeat ($urandom_range(3, 0)) @(posedge clk);
        end
        finish_test("random requests");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: source/vector_engine.sv
// Top of the vector engine, draws one ROM shape at an offset as a stream of pixel strobes
`timescale 1ns/1ps

module vector_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  vector_pkg::shape_id_t shape,
    input  vector_pkg::coord_t    offset_x,
    input  vector_pkg::coord_t    offset_y,
    output logic                  busy,
    output logic                  done,
    output logic                  pixel_valid,
    output vector_pkg::coord_t    pixel_x,
    output vector_pkg::coord_t    pixel_y
);
    import vector_pkg::*;

    rom_addr_t   addr;
    list_entry_t entry;

    // Segment link
    logic   seg_start;
    logic   seg_done;
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;

    display_list_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .shape     (shape),
        .offset_x  (offset_x),
        .offset_y  (offset_y),
        .entry     (entry),
        .seg_done  (seg_done),
        .addr      (addr),
        .seg_start (seg_start),
        .x0        (x0),
        .y0        (y0),
        .x1        (x1),
        .y1        (y1),
        .busy      (busy),
        .done      (done)
    );

    shape_rom u_rom (
        .addr  (addr),
        .entry (entry)
    );

    line_rasterizer u_rasterizer (
        .clk         (clk),
        .rst         (rst),
        .seg_start   (seg_start),
        .x0          (x0),
        .y0          (y0),
        .x1          (x1),
        .y1          (y1),
        .pixel_valid (pixel_valid),
        .seg_done    (seg_done),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y)
    );

endmodule

// File: source/line_rasterizer.sv
// Bresenham line stepper, turns one segment into a stream of one pixel strobe per cycle
`timescale 1ns/1ps

module line_rasterizer (
    input  logic               clk,
    input  logic               rst,
    input  logic               seg_start,
    input  vector_pkg::coord_t x0,
    input  vector_pkg::coord_t y0,
    input  vector_pkg::coord_t x1,
    input  vector_pkg::coord_t y1,
    output logic               pixel_valid,
    output logic               seg_done,
    output vector_pkg::coord_t pixel_x,
    output vector_pkg::coord_t pixel_y
);
    import vector_pkg::*;

    // Incoming segment
    logic signed [err_width-1:0] dx;
    logic signed [err_width-1:0] dy;
    logic signed [err_width-1:0] adx_in;
    logic signed [err_width-1:0] ady_in;

    // Running segment
    logic                        active;
    coord_t                      cur_x;
    coord_t                      cur_y;
    coord_t                      end_x;
    coord_t                      end_y;
    logic                        neg_x;
    logic                        neg_y;
    logic signed [err_width-1:0] adx;
    logic signed [err_width-1:0] ady;
    logic signed [err_width-1:0] err;
    logic signed [err_width-1:0] err_next;
    logic signed [err_width-1:0] e2;

    logic step_x;
    logic step_y;
    logic at_end;

    ////////////////////
    // Setup

    // Plain signed difference, the line never wraps across the screen edge
    assign dx = $signed({{(err_width-coord_width){1'b0}}, x1})
              - $signed({{(err_width-coord_width){1'b0}}, x0});
    assign dy = $signed({{(err_width-coord_width){1'b0}}, y1})
              - $signed({{(err_width-coord_width){1'b0}}, y0});

    assign adx_in = dx[err_width-1] ? -dx : dx;
    assign ady_in = dy[err_width-1] ? -dy : dy;

    ////////////////////
    // Step decision

    assign e2     = err <<< 1;
    assign step_x = (e2 >= -ady);
    assign step_y = (e2 <= adx);
    assign at_end = (cur_x == end_x) && (cur_y == end_y);

    always_comb begin
        err_next = err;
        if (step_x) begin
            err_next = err_next - ady;
        end
        if (step_y) begin
            err_next = err_next + adx;
        end
    end

    assign pixel_valid = active;
    assign seg_done    = active && at_end;  // Rides on the last pixel
    assign pixel_x     = cur_x;
    assign pixel_y     = cur_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (seg_start) begin
            active <= 1'b1;
        end else if (active && at_end) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (seg_start) begin
            cur_x <= x0;  // First pixel is the start point
            cur_y <= y0;
            end_x <= x1;
            end_y <= y1;
            neg_x <= dx[err_width-1];
            neg_y <= dy[err_width-1];
            adx   <= adx_in;
            ady   <= ady_in;
            err   <= adx_in - ady_in;
        end else if (active && !at_end) begin
            if (step_x) begin
                cur_x <= neg_x ? cur_x - 1'b1 : cur_x + 1'b1;
            end
            if (step_y) begin
                cur_y <= neg_y ? cur_y - 1'b1 : cur_y + 1'b1;
            end
            err <= err_next;
        end
    end

endmodule

// File: source/display_list_sequencer.sv
// Walks one shape's display list, keeps the pen and hands offset segments to the rasterizer
`timescale 1ns/1ps

module display_list_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  vector_pkg::shape_id_t   shape,
    input  vector_pkg::coord_t      offset_x,
    input  vector_pkg::coord_t      offset_y,
    input  vector_pkg::list_entry_t entry,
    input  logic                    seg_done,
    output vector_pkg::rom_addr_t   addr,
    output logic                    seg_start,
    output vector_pkg::coord_t      x0,
    output vector_pkg::coord_t      y0,
    output vector_pkg::coord_t      x1,
    output vector_pkg::coord_t      y1,
    output logic                    busy,
    output logic                    done
);
    import vector_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait_seg,
        st_finish
    } state_t;

    state_t state;

    coord_t off_x;
    coord_t off_y;
    coord_t pen_x;
    coord_t pen_y;
    coord_t point_x;
    coord_t point_y;

    logic is_move;
    logic is_line;
    logic is_end;

    ////////////////////
    // Entry decode

    // Offset wraps modulo 256, sprites near x=255 rely on it
    assign point_x = entry.x + off_x;
    assign point_y = entry.y + off_y;

    assign is_move = entry.pos && !entry.line;
    assign is_line = entry.line && !entry.pos;
    assign is_end  = entry.line && entry.pos;

    ////////////////////
    // Outputs

    assign seg_start = (state == st_fetch) && is_line;  // Issue in the decode cycle
    assign x0 = pen_x;
    assign y0 = pen_y;
    assign x1 = point_x;
    assign y1 = point_y;

    assign busy = (state != st_idle);
    assign done = (state == st_finish);  // Last busy cycle

    ////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (is_line) begin
                        state <= st_wait_seg;
                    end else if (is_end) begin
                        state <= st_finish;
                    end
                end
                st_wait_seg: begin
                    // Next entry is already on the ROM output
                    if (seg_done) begin
                        state <= st_fetch;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Pen, offset and list pointer
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (start) begin
                    off_x <= offset_x;
                    off_y <= offset_y;
                    pen_x <= offset_x;  // Pen starts at the shape origin
                    pen_y <= offset_y;
                    addr  <= shape_base[shape];
                end
            end
            st_fetch: begin
                if (!is_end) begin
                    addr <= addr + 1'b1;  // Prefetch while a segment runs
                end
                if (is_move || is_line) begin
                    pen_x <= point_x;
                    pen_y <= point_y;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: source/shape_rom.sv
// Combinational display-list table holding the frame, cursor, patriot base and missile shapes
`timescale 1ns/1ps

module shape_rom (
    input  vector_pkg::rom_addr_t   addr,
    output vector_pkg::list_entry_t entry
);
    import vector_pkg::*;

    always_comb begin
        case (addr)
            //                x        y        line  pos
            ////////////////////
            // Frame
            7'd0:  entry = {8'd0,   8'd254, 1'b0, 1'b1};
            7'd1:  entry = {8'd0,   8'd0,   1'b1, 1'b0};
            7'd2:  entry = {8'd254, 8'd0,   1'b1, 1'b0};
            7'd3:  entry = {8'd254, 8'd254, 1'b1, 1'b0};
            7'd4:  entry = {8'd0,   8'd254, 1'b1, 1'b0};
            7'd5:  entry = {8'd0,   8'd254, 1'b1, 1'b1};   // End

            ////////////////////
            // Cursor, a plain cross
            7'd6:  entry = {8'd22,  8'd50,  1'b0, 1'b1};
            7'd7:  entry = {8'd42,  8'd50,  1'b1, 1'b0};
            7'd8:  entry = {8'd32,  8'd40,  1'b0, 1'b1};
            7'd9:  entry = {8'd32,  8'd60,  1'b1, 1'b0};
            7'd10: entry = {8'd22,  8'd50,  1'b1, 1'b1};   // End

            ////////////////////
            // Patriot base
            7'd11: entry = {8'd7,   8'd6,   1'b0, 1'b1};   // Ground line
            7'd12: entry = {8'd11,  8'd7,   1'b1, 1'b0};
            7'd13: entry = {8'd11,  8'd9,   1'b1, 1'b0};
            7'd14: entry = {8'd22,  8'd9,   1'b1, 1'b0};
            7'd15: entry = {8'd22,  8'd7,   1'b1, 1'b0};
            7'd16: entry = {8'd27,  8'd6,   1'b1, 1'b0};
            7'd17: entry = {8'd3,   8'd14,  1'b0, 1'b1};   // Launcher rail
            7'd18: entry = {8'd22,  8'd31,  1'b1, 1'b0};
            7'd19: entry = {8'd25,  8'd27,  1'b1, 1'b0};
            7'd20: entry = {8'd8,   8'd10,  1'b1, 1'b0};
            7'd21: entry = {8'd4,   8'd14,  1'b1, 1'b0};
            7'd22: entry = {8'd15,  8'd9,   1'b0, 1'b1};   // Struts
            7'd23: entry = {8'd14,  8'd16,  1'b1, 1'b0};
            7'd24: entry = {8'd18,  8'd9,   1'b0, 1'b1};
            7'd25: entry = {8'd16,  8'd18,  1'b1, 1'b0};
            7'd26: entry = {8'd16,  8'd18,  1'b1, 1'b1};   // End

            ////////////////////
            // Missile, a single dot at the offset
            7'd27: entry = {8'd0,   8'd0,   1'b0, 1'b1};
            7'd28: entry = {8'd0,   8'd0,   1'b1, 1'b0};
            7'd29: entry = {8'd0,   8'd0,   1'b1, 1'b1};   // End

            default: entry = end_entry;  // Past the table
        endcase
    end

endmodule

// File: source/vector_pkg.sv
// Shared widths, display-list entry layout and shape start addresses, imported by every RTL block
package vector_pkg;

    ////////////////////
    // Widths

    localparam int coord_width = 8;     // Screen is 256 x 256
    localparam int rom_addr_width = 7;  // Kept table fits in 128 entries
    localparam int err_width = coord_width + 4;  // Bresenham error and doubled error

    typedef logic [coord_width-1:0] coord_t;
    typedef logic [rom_addr_width-1:0] rom_addr_t;

    ////////////////////
    // Shapes

    typedef enum logic [1:0] {
        shape_frame        = 2'd0,
        shape_cursor       = 2'd1,
        shape_patriot_base = 2'd2,
        shape_missile      = 2'd3
    } shape_id_t;

    // One display-list word, same bit order as the game ROM
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   line;
        logic   pos;
    } list_entry_t;

    localparam rom_addr_t frame_addr        = 7'd0;
    localparam rom_addr_t cursor_addr       = 7'd6;
    localparam rom_addr_t patriot_base_addr = 7'd11;
    localparam rom_addr_t missile_addr      = 7'd27;

    // Indexed by shape_id_t
    localparam rom_addr_t shape_base [4] = '{
        frame_addr,
        cursor_addr,
        patriot_base_addr,
        missile_addr
    };

    // Line and pos both set closes a shape
    localparam list_entry_t end_entry = '{x: '0, y: '0, line: 1'b1, pos: 1'b1};

endpackage
